/* design/pio_defs.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, opcodes and operand codes of the PIO state machine core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PIO_DEFS_SVH
`define PIO_DEFS_SVH

`define PIO_DATA_W        32
`define PIO_ADDR_W        5
`define PIO_INSTR_W       16
`define PIO_CNT_W         6   // Holds 0 to 32

`define PIO_OP_JMP        3'd0
`define PIO_OP_WAIT       3'd1
`define PIO_OP_IN         3'd2
`define PIO_OP_OUT        3'd3
`define PIO_OP_PUSHPULL   3'd4
`define PIO_OP_MOV        3'd5
`define PIO_OP_IRQ        3'd6
`define PIO_OP_SET        3'd7

`define PIO_SRC_PINS      3'd0
`define PIO_SRC_X         3'd1
`define PIO_SRC_Y         3'd2
`define PIO_SRC_NULL      3'd3
`define PIO_DST_PINDIRS   3'd4
`define PIO_DST_PC        3'd5
`define PIO_SRC_ISR       3'd6
`define PIO_SRC_OSR       3'd7

`define PIO_MOVOP_NONE    2'd0
`define PIO_MOVOP_INV     2'd1
`define PIO_MOVOP_REV     2'd2

`define PIO_OSR_EMPTY_CNT 6'd32

`endif

/* design/pio_isa_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction word layout, shared by the executor and the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package pio_isa_pkg;

  // Same 16 bits, read either generically or as a MOV
  typedef union packed {
    struct packed {
      logic [2:0] opcode;
      logic [4:0] delay_side;  // Not decoded by this core
      logic [2:0] op1;         // Condition, source or destination
      logic [4:0] op2;         // Address, bit count or data
    } gen;
    struct packed {
      logic [2:0] opcode;
      logic [4:0] delay_side;
      logic [2:0] dest;
      logic [1:0] mov_op;      // None, invert or bit reverse
      logic [2:0] mov_src;
    } mov;
  } instr_u;

endpackage

`default_nettype wire

/* design/pio_wr_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write value and register strobes from the executor to the registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pio_defs.svh"

interface pio_wr_if;
  logic [`PIO_DATA_W-1:0] wr_data;
  logic [`PIO_CNT_W-1:0]  bit_count;
  logic jmp;
  logic set_x;
  logic set_y;
  logic dec_x;
  logic dec_y;
  logic load_isr;
  logic shift_isr;
  logic load_osr;
  logic shift_osr;
  logic pins_set;    // SET window
  logic dirs_set;
  logic pins_out;    // OUT and MOV window
  logic dirs_out;
  logic advance;     // Step done, PC moves on

  modport exec (output wr_data, bit_count, jmp, set_x, set_y, dec_x, dec_y,
                load_isr, shift_isr, load_osr, shift_osr,
                pins_set, dirs_set, pins_out, dirs_out, advance);
  modport sink (input wr_data, bit_count, jmp, set_x, set_y, dec_x, dec_y,
                load_isr, shift_isr, load_osr, shift_osr,
                pins_set, dirs_set, pins_out, dirs_out, advance);
endinterface

`default_nettype wire

/* design/pio_exec.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-cycle decoder and executor; turns one instruction into strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pio_defs.svh"

module pio_exec (
  input  logic                   en,
  input  pio_isa_pkg::instr_u    instr,
  input  logic [`PIO_DATA_W-1:0] din,
  input  logic                   full,
  input  logic                   empty,
  input  logic [`PIO_DATA_W-1:0] input_pins,
  input  logic [4:0]             jmp_pin,
  input  logic [4:0]             pins_in_base,
  input  logic [4:0]             osr_threshold,  // 0 means 32
  input  logic [`PIO_DATA_W-1:0] x_val,
  input  logic [`PIO_DATA_W-1:0] y_val,
  input  logic [`PIO_DATA_W-1:0] isr_val,
  input  logic [`PIO_DATA_W-1:0] osr_val,
  input  logic [`PIO_CNT_W-1:0]  isr_count,
  input  logic [`PIO_CNT_W-1:0]  osr_count,
  input  logic                   in_shift_dir,   // 1 shifts right
  input  logic                   out_shift_dir,  // 1 shifts right
  output logic                   push,
  output logic                   pull,
  output logic [`PIO_DATA_W-1:0] dout,
  pio_wr_if.exec                 wr
);
  localparam logic [`PIO_CNT_W-1:0] FULL_CNT = `PIO_DATA_W;

  logic [2*`PIO_DATA_W-1:0] pins_dbl;
  logic [`PIO_DATA_W-1:0]   pins_rot;
  logic [`PIO_CNT_W-1:0]    n;
  logic [`PIO_CNT_W-1:0]    osr_thr;
  logic [`PIO_DATA_W-1:0]   out_mask;
  logic [`PIO_DATA_W-1:0]   out_data;
  logic [`PIO_DATA_W-1:0]   op2_ext;
  logic [`PIO_DATA_W-1:0]   mov_raw;
  logic [`PIO_DATA_W-1:0]   mov_val;
  logic                     stall;

  // Pins seen from the in base, rotated right
  assign pins_dbl = {input_pins, input_pins} >> pins_in_base;
  assign pins_rot = pins_dbl[`PIO_DATA_W-1:0];

  assign n        = (instr.gen.op2 == 5'd0) ? FULL_CNT : {1'b0, instr.gen.op2};
  assign osr_thr  = (osr_threshold == 5'd0) ? FULL_CNT : {1'b0, osr_threshold};
  assign op2_ext  = {{(`PIO_DATA_W-5){1'b0}}, instr.gen.op2};
  assign out_mask = ~({`PIO_DATA_W{1'b1}} << n);
  assign out_data = out_shift_dir ? (osr_val & out_mask) : (osr_val >> (FULL_CNT - n));

  function automatic logic [`PIO_DATA_W-1:0] src_sel(input logic [2:0] code);
    case (code)
      `PIO_SRC_PINS: return pins_rot;
      `PIO_SRC_X:    return x_val;
      `PIO_SRC_Y:    return y_val;
      `PIO_SRC_NULL: return '0;
      `PIO_SRC_ISR:  return isr_val;
      `PIO_SRC_OSR:  return osr_val;
      // Codes 4 and 5 read both shift counts
      default:       return {{(`PIO_DATA_W-2*`PIO_CNT_W){1'b0}}, isr_count, osr_count};
    endcase
  endfunction

  assign mov_raw = src_sel(instr.mov.mov_src);

  always_comb begin
    case (instr.mov.mov_op)
      `PIO_MOVOP_NONE: mov_val = mov_raw;
      `PIO_MOVOP_INV:  mov_val = ~mov_raw;
      `PIO_MOVOP_REV:  mov_val = {<<{mov_raw}};
      default:         mov_val = mov_raw;  // Reserved
    endcase
  end

  always_comb begin
    wr.wr_data   = '0;
    wr.bit_count = n;
    wr.jmp       = 1'b0;
    wr.set_x     = 1'b0;
    wr.set_y     = 1'b0;
    wr.dec_x     = 1'b0;
    wr.dec_y     = 1'b0;
    wr.load_isr  = 1'b0;
    wr.shift_isr = 1'b0;
    wr.load_osr  = 1'b0;
    wr.shift_osr = 1'b0;
    wr.pins_set  = 1'b0;
    wr.dirs_set  = 1'b0;
    wr.pins_out  = 1'b0;
    wr.dirs_out  = 1'b0;
    push  = 1'b0;
    pull  = 1'b0;
    stall = 1'b0;
    case (instr.gen.opcode)
      `PIO_OP_JMP: begin
        wr.wr_data = op2_ext;
        case (instr.gen.op1)
          3'd0: wr.jmp = 1'b1;
          3'd1: wr.jmp = (x_val == '0);
          3'd2: begin
            wr.jmp   = (x_val != '0);  // Tested before the decrement
            wr.dec_x = 1'b1;
          end
          3'd3: wr.jmp = (y_val == '0);
          3'd4: begin
            wr.jmp   = (y_val != '0);
            wr.dec_y = 1'b1;
          end
          3'd5: wr.jmp = (x_val != y_val);
          3'd6: wr.jmp = input_pins[jmp_pin];
          default: wr.jmp = (osr_count < osr_thr);  // OSR not empty
        endcase
      end
      `PIO_OP_IN: begin
        wr.wr_data   = src_sel(instr.gen.op1);
        wr.shift_isr = 1'b1;
      end
      `PIO_OP_OUT: begin
        wr.wr_data   = out_data;
        wr.shift_osr = 1'b1;
        case (instr.gen.op1)
          `PIO_SRC_PINS:    wr.pins_out = 1'b1;
          `PIO_SRC_X:       wr.set_x    = 1'b1;
          `PIO_SRC_Y:       wr.set_y    = 1'b1;
          `PIO_DST_PINDIRS: wr.dirs_out = 1'b1;
          `PIO_DST_PC:      wr.jmp      = 1'b1;
          `PIO_SRC_ISR:     wr.load_isr = 1'b1;
          default: ;                    // Bits are discarded
        endcase
      end
      `PIO_OP_PUSHPULL: begin
        if (!instr.gen.op1[2]) begin
          if (!full) begin
            push        = 1'b1;
            wr.load_isr = 1'b1;         // ISR cleared after the push
          end else begin
            stall = instr.gen.op1[0];   // Non-blocking push is dropped
          end
        end else if (!empty) begin
          pull        = 1'b1;
          wr.wr_data  = din;
          wr.load_osr = 1'b1;
        end else if (instr.gen.op1[0]) begin
          stall = 1'b1;
        end else begin
          wr.wr_data  = x_val;          // Empty non-blocking pull takes X
          wr.load_osr = 1'b1;
        end
      end
      `PIO_OP_MOV: begin
        wr.wr_data = mov_val;
        case (instr.mov.dest)
          `PIO_SRC_PINS: wr.pins_out = 1'b1;
          `PIO_SRC_X:    wr.set_x    = 1'b1;
          `PIO_SRC_Y:    wr.set_y    = 1'b1;
          `PIO_DST_PC:   wr.jmp      = 1'b1;
          `PIO_SRC_ISR:  wr.load_isr = 1'b1;
          `PIO_SRC_OSR:  wr.load_osr = 1'b1;
          default: ;
        endcase
      end
      `PIO_OP_SET: begin
        wr.wr_data = op2_ext;
        case (instr.gen.op1)
          `PIO_SRC_PINS:    wr.pins_set = 1'b1;
          `PIO_SRC_X:       wr.set_x    = 1'b1;
          `PIO_SRC_Y:       wr.set_y    = 1'b1;
          `PIO_DST_PINDIRS: wr.dirs_set = 1'b1;
          default: ;
        endcase
      end
      `PIO_OP_WAIT, `PIO_OP_IRQ: ;      // No-ops here
    endcase
    // Nothing commits while disabled or stalled
    if (!en || stall) begin
      wr.jmp       = 1'b0;
      wr.set_x     = 1'b0;
      wr.set_y     = 1'b0;
      wr.dec_x     = 1'b0;
      wr.dec_y     = 1'b0;
      wr.load_isr  = 1'b0;
      wr.shift_isr = 1'b0;
      wr.load_osr  = 1'b0;
      wr.shift_osr = 1'b0;
      wr.pins_set  = 1'b0;
      wr.dirs_set  = 1'b0;
      wr.pins_out  = 1'b0;
      wr.dirs_out  = 1'b0;
      push = 1'b0;
      pull = 1'b0;
    end
    wr.advance = en && !stall;
    dout = push ? isr_val : '0;
  end

endmodule

`default_nettype wire

/* design/pio_pc.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program counter with jump, stall and wrap
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pio_defs.svh"

module pio_pc (
  input  logic                   clk,
  input  logic                   arst_n,
  pio_wr_if.sink                 wr,
  input  logic [`PIO_ADDR_W-1:0] wrap_top,
  input  logic [`PIO_ADDR_W-1:0] wrap_bottom,
  output logic [`PIO_ADDR_W-1:0] pc
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (wr.jmp) begin
      pc <= wr.wr_data[`PIO_ADDR_W-1:0];
    end else if (wr.advance) begin
      pc <= (pc == wrap_top) ? wrap_bottom : pc + 1'b1;  // Wrap back at the top
    end
  end

endmodule

`default_nettype wire

/* design/pio_scratch.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scratch register, X or Y as chosen by IS_Y
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pio_defs.svh"

module pio_scratch #(
  parameter bit IS_Y = 1'b0
) (
  input  logic                   clk,
  input  logic                   arst_n,
  pio_wr_if.sink                 wr,
  output logic [`PIO_DATA_W-1:0] val
);
  logic set;
  logic dec;

  assign set = IS_Y ? wr.set_y : wr.set_x;
  assign dec = IS_Y ? wr.dec_y : wr.dec_x;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      val <= '0;
    end else if (set) begin
      val <= wr.wr_data;
    end else if (dec) begin
      val <= val - 1'b1;  // Wraps below zero
    end
  end

endmodule

`default_nettype wire

/* design/pio_isr.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input shift register and its shift counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pio_defs.svh"

module pio_isr (
  input  logic                   clk,
  input  logic                   arst_n,
  pio_wr_if.sink                 wr,
  input  logic                   in_shift_dir,  // 1 shifts right
  output logic [`PIO_DATA_W-1:0] val,
  output logic [`PIO_CNT_W-1:0]  count
);
  localparam logic [`PIO_CNT_W:0] FULL = `PIO_DATA_W;

  logic [`PIO_DATA_W-1:0] mask;
  logic [`PIO_CNT_W:0]    sum;

  assign mask = ~({`PIO_DATA_W{1'b1}} << wr.bit_count);
  assign sum  = count + wr.bit_count;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      val   <= '0;
      count <= '0;
    end else if (wr.load_isr) begin
      val   <= wr.wr_data;
      count <= '0;
    end else if (wr.shift_isr) begin
      if (in_shift_dir) begin
        val <= (val >> wr.bit_count) | (wr.wr_data << (FULL - wr.bit_count));  // In at top
      end else begin
        val <= (val << wr.bit_count) | (wr.wr_data & mask);
      end
      count <= (sum > FULL) ? FULL[`PIO_CNT_W-1:0] : sum[`PIO_CNT_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* design/pio_osr.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output shift register and its shift counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pio_defs.svh"

module pio_osr (
  input  logic                   clk,
  input  logic                   arst_n,
  pio_wr_if.sink                 wr,
  input  logic                   out_shift_dir,  // 1 shifts right
  output logic [`PIO_DATA_W-1:0] val,
  output logic [`PIO_CNT_W-1:0]  count
);
  localparam logic [`PIO_CNT_W:0] FULL = `PIO_DATA_W;

  logic [`PIO_CNT_W:0] sum;

  assign sum = count + wr.bit_count;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      val   <= '0;
      count <= `PIO_OSR_EMPTY_CNT;  // Starts out empty
    end else if (wr.load_osr) begin
      val   <= wr.wr_data;
      count <= '0;
    end else if (wr.shift_osr) begin
      val   <= out_shift_dir ? (val >> wr.bit_count) : (val << wr.bit_count);
      count <= (sum > FULL) ? FULL[`PIO_CNT_W-1:0] : sum[`PIO_CNT_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* design/pio_pins.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output pin and direction registers, written through a base/count window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pio_defs.svh"

module pio_pins (
  input  logic                   clk,
  input  logic                   arst_n,
  pio_wr_if.sink                 wr,
  input  logic [4:0]             pins_out_base,
  input  logic [5:0]             pins_out_count,
  input  logic [4:0]             pins_set_base,
  input  logic [2:0]             pins_set_count,
  output logic [`PIO_DATA_W-1:0] output_pins,
  output logic [`PIO_DATA_W-1:0] pin_directions
);

  // Bit i of data goes to bit (base + i) mod 32, for i below count
  function automatic logic [`PIO_DATA_W-1:0] win_write(
    input logic [`PIO_DATA_W-1:0] old,
    input logic [`PIO_DATA_W-1:0] data,
    input logic [4:0]             base,
    input logic [5:0]             count
  );
    logic [`PIO_DATA_W-1:0] w;
    logic [4:0]             idx;
    w = old;
    for (int i = 0; i < `PIO_DATA_W; i++) begin
      idx = base + 5'(i);
      if (i < count) w[idx] = data[i];
    end
    return w;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      output_pins    <= '0;
      pin_directions <= '0;
    end else begin
      if (wr.pins_set)
        output_pins <= win_write(output_pins, wr.wr_data, pins_set_base, {3'b0, pins_set_count});
      if (wr.pins_out)
        output_pins <= win_write(output_pins, wr.wr_data, pins_out_base, pins_out_count);
      if (wr.dirs_set)
        pin_directions <= win_write(pin_directions, wr.wr_data, pins_set_base,
                                    {3'b0, pins_set_count});
      if (wr.dirs_out)
        pin_directions <= win_write(pin_directions, wr.wr_data, pins_out_base, pins_out_count);
    end
  end

endmodule

`default_nettype wire

/* design/pio_sm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PIO state machine top; one instruction per enabled clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pio_defs.svh"

module pio_sm (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    en,
  input  logic [`PIO_INSTR_W-1:0] instr,
  input  logic [`PIO_DATA_W-1:0]  din,
  input  logic                    full,
  input  logic                    empty,
  input  logic [`PIO_DATA_W-1:0]  input_pins,
  input  logic [4:0]              jmp_pin,
  input  logic [`PIO_ADDR_W-1:0]  wrap_top,
  input  logic [`PIO_ADDR_W-1:0]  wrap_bottom,
  input  logic [4:0]              pins_in_base,
  input  logic [4:0]              pins_out_base,
  input  logic [5:0]              pins_out_count,
  input  logic [4:0]              pins_set_base,
  input  logic [2:0]              pins_set_count,
  input  logic                    in_shift_dir,
  input  logic                    out_shift_dir,
  input  logic [4:0]              osr_threshold,
  output logic [`PIO_ADDR_W-1:0]  pc,
  output logic                    push,     // To RX FIFO
  output logic                    pull,     // From TX FIFO
  output logic [`PIO_DATA_W-1:0]  dout,
  output logic [`PIO_DATA_W-1:0]  output_pins,
  output logic [`PIO_DATA_W-1:0]  pin_directions
);
  logic [`PIO_DATA_W-1:0] x_val;
  logic [`PIO_DATA_W-1:0] y_val;
  logic [`PIO_DATA_W-1:0] isr_val;
  logic [`PIO_DATA_W-1:0] osr_val;
  logic [`PIO_CNT_W-1:0]  isr_count;
  logic [`PIO_CNT_W-1:0]  osr_count;

  pio_wr_if wr ();

  pio_exec u_exec (
    .en, .instr, .din, .full, .empty, .input_pins, .jmp_pin, .pins_in_base,
    .osr_threshold, .x_val, .y_val, .isr_val, .osr_val, .isr_count, .osr_count,
    .in_shift_dir, .out_shift_dir, .push, .pull, .dout, .wr(wr.exec)
  );

  pio_pc u_pc (.clk, .arst_n, .wr(wr.sink), .wrap_top, .wrap_bottom, .pc);

  pio_scratch #(.IS_Y(1'b0)) u_x (.clk, .arst_n, .wr(wr.sink), .val(x_val));
  pio_scratch #(.IS_Y(1'b1)) u_y (.clk, .arst_n, .wr(wr.sink), .val(y_val));

  pio_isr u_isr (
    .clk, .arst_n, .wr(wr.sink), .in_shift_dir, .val(isr_val), .count(isr_count)
  );

  pio_osr u_osr (
    .clk, .arst_n, .wr(wr.sink), .out_shift_dir, .val(osr_val), .count(osr_count)
  );

  pio_pins u_pins (
    .clk, .arst_n, .wr(wr.sink), .pins_out_base, .pins_out_count,
    .pins_set_base, .pins_set_count, .output_pins, .pin_directions
  );

endmodule

`default_nettype wire

/* verif/pio_sm_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the PIO state machine core
// Steps through a table of instructions and checks every step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pio_defs.svh"

module pio_sm_tb;
  localparam int STEP_LIMIT  = 16;  // Rows allowed per test
  localparam int RESET_LIMIT = 10;
  localparam int NUM_TESTS   = 5;

  typedef struct packed {
    int          test;
    logic        en;
    logic [15:0] instr;
    logic [31:0] din;
    logic        full;
    logic        empty;
    logic [31:0] input_pins;
    logic [4:0]  exp_pc;    // After the edge
    logic        exp_push;  // Before the edge
    logic        exp_pull;
    logic [31:0] exp_dout;
    logic [31:0] exp_pins;  // After the edge
    logic [31:0] exp_dirs;
  } row_t;

  logic        clk;
  logic        arst_n;
  logic        en;
  logic [15:0] instr;
  logic [31:0] din;
  logic        full;
  logic        empty;
  logic [31:0] input_pins;
  logic [4:0]  pc;
  logic        push;
  logic        pull;
  logic [31:0] dout;
  logic [31:0] output_pins;
  logic [31:0] pin_directions;

  row_t        rows[$];
  logic        nx_en;      // Inputs and sticky expectations of the next row
  logic [31:0] nx_din;
  logic        nx_full;
  logic        nx_empty;
  logic [31:0] nx_pins;
  logic [31:0] nx_dirs;
  int          errors;
  int          test_errs[NUM_TESTS+1];
  int          cur_test;
  int          tests_ok;
  int          tests_bad;
  int          idx;
  int          steps;
  int          cycles;

  pio_sm DUT (
    .clk, .arst_n, .en, .instr, .din, .full, .empty, .input_pins,
    .jmp_pin(5'd3), .wrap_top(5'd7), .wrap_bottom(5'd2), .pins_in_base(5'd0),
    .pins_out_base(5'd8), .pins_out_count(6'd8), .pins_set_base(5'd4), .pins_set_count(3'd3),
    .in_shift_dir(1'b1), .out_shift_dir(1'b1),
    .osr_threshold(5'd0),  // Field value 0 selects 32
    .pc, .push, .pull, .dout, .output_pins, .pin_directions
  );

  always #50 clk = ~clk;

  initial begin
    arst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1 arst_n = 1'b1;
  end

  function automatic logic [15:0] encode_instr(input logic [2:0] opcode,
                                               input logic [2:0] op1, input logic [4:0] op2);
    pio_isa_pkg::instr_u w;
    w            = '0;
    w.gen.opcode = opcode;
    w.gen.op1    = op1;
    w.gen.op2    = op2;
    return w;
  endfunction

  function automatic logic [15:0] mov_instr(input logic [2:0] dest, input logic [1:0] op,
                                            input logic [2:0] src);
    pio_isa_pkg::instr_u w;
    w             = '0;
    w.mov.opcode  = `PIO_OP_MOV;
    w.mov.dest    = dest;
    w.mov.mov_op  = op;
    w.mov.mov_src = src;
    return w;
  endfunction

  task automatic fifo_row(input int test, input logic [15:0] ins, input logic [4:0] pc_exp,
                          input logic push_exp, input logic pull_exp,
                          input logic [31:0] dout_exp, input logic [31:0] pins_exp);
    row_t r;
    r = '{test, nx_en, ins, nx_din, nx_full, nx_empty, nx_pins, pc_exp,
          push_exp, pull_exp, dout_exp, pins_exp, nx_dirs};
    rows.push_back(r);
  endtask

  task automatic add_row(input int test, input logic [15:0] ins, input logic [4:0] pc_exp,
                         input logic [31:0] pins_exp);
    fifo_row(test, ins, pc_exp, 1'b0, 1'b0, 32'h0, pins_exp);
  endtask

  task automatic build_table();
    nx_en    = 1'b0;
    nx_din   = '0;
    nx_full  = 1'b0;
    nx_empty = 1'b1;
    nx_pins  = '0;
    nx_dirs  = '0;
    add_row(1, encode_instr(`PIO_OP_SET, `PIO_SRC_X, 5'd3), 5'd0, 32'h0);  // Disabled
    add_row(1, encode_instr(`PIO_OP_SET, `PIO_SRC_PINS, 5'd7), 5'd0, 32'h0);
    nx_en   = 1'b1;
    nx_dirs = 32'h70;  // Set window covers bits 4 to 6
    add_row(2, encode_instr(`PIO_OP_SET, `PIO_DST_PINDIRS, 5'd7), 5'd1, 32'h0);
    add_row(2, encode_instr(`PIO_OP_SET, `PIO_SRC_PINS, 5'd5), 5'd2, 32'h50);
    add_row(2, encode_instr(`PIO_OP_SET, `PIO_SRC_X, 5'd3), 5'd3, 32'h50);
    repeat (3) add_row(2, encode_instr(`PIO_OP_JMP, 3'd2, 5'd3), 5'd3, 32'h50);
    add_row(2, encode_instr(`PIO_OP_JMP, 3'd2, 5'd3), 5'd4, 32'h50);  // X ends at all ones
    add_row(2, mov_instr(`PIO_SRC_PINS, `PIO_MOVOP_NONE, `PIO_SRC_X), 5'd5, 32'hFF50);
    add_row(3, encode_instr(`PIO_OP_SET, `PIO_SRC_X, 5'd21), 5'd6, 32'hFF50);
    nx_pins = 32'h0000_00A5;
    add_row(3, encode_instr(`PIO_OP_IN, `PIO_SRC_PINS, 5'd8), 5'd7, 32'hFF50);
    add_row(3, encode_instr(`PIO_OP_IN, `PIO_SRC_X, 5'd8), 5'd2, 32'hFF50);  // Wraps to 2
    nx_full = 1'b1;
    repeat (3) add_row(3, encode_instr(`PIO_OP_PUSHPULL, 3'b001, 5'd0), 5'd2, 32'hFF50);
    nx_full = 1'b0;
    fifo_row(3, encode_instr(`PIO_OP_PUSHPULL, 3'b001, 5'd0), 5'd3, 1'b1, 1'b0,
             32'h15A5_0000, 32'hFF50);
    nx_full = 1'b1;
    add_row(3, encode_instr(`PIO_OP_PUSHPULL, 3'b000, 5'd0), 5'd4, 32'hFF50);  // Dropped
    nx_full = 1'b0;
    repeat (2) add_row(4, encode_instr(`PIO_OP_PUSHPULL, 3'b101, 5'd0), 5'd4, 32'hFF50);
    nx_empty = 1'b0;
    nx_din   = 32'h1234_5678;
    fifo_row(4, encode_instr(`PIO_OP_PUSHPULL, 3'b101, 5'd0), 5'd5, 1'b0, 1'b1,
             32'h0, 32'hFF50);
    nx_empty = 1'b1;
    add_row(4, encode_instr(`PIO_OP_OUT, `PIO_SRC_PINS, 5'd8), 5'd6, 32'h7850);
    add_row(4, encode_instr(`PIO_OP_JMP, 3'd7, 5'd10), 5'd10, 32'h7850);  // 8 of 32 used
    add_row(4, encode_instr(`PIO_OP_OUT, `PIO_SRC_NULL, 5'd0), 5'd11, 32'h7850);
    add_row(4, encode_instr(`PIO_OP_JMP, 3'd7, 5'd20), 5'd12, 32'h7850);  // OSR now empty
    add_row(4, encode_instr(`PIO_OP_PUSHPULL, 3'b100, 5'd0), 5'd13, 32'h7850);
    add_row(4, encode_instr(`PIO_OP_OUT, `PIO_SRC_PINS, 5'd8), 5'd14, 32'h1550);  // X = 21
    add_row(5, encode_instr(`PIO_OP_SET, `PIO_SRC_Y, 5'd6), 5'd15, 32'h1550);
    add_row(5, mov_instr(`PIO_SRC_PINS, `PIO_MOVOP_INV, `PIO_SRC_Y), 5'd16, 32'hF950);
    nx_pins = 32'h3500_0000;
    add_row(5, mov_instr(`PIO_SRC_X, `PIO_MOVOP_NONE, `PIO_SRC_PINS), 5'd17, 32'hF950);
    add_row(5, mov_instr(`PIO_SRC_PINS, `PIO_MOVOP_REV, `PIO_SRC_X), 5'd18, 32'hAC50);
    add_row(5, encode_instr(`PIO_OP_JMP, 3'd0, 5'd5), 5'd5, 32'hAC50);
    add_row(5, mov_instr(`PIO_SRC_Y, `PIO_MOVOP_NONE, `PIO_SRC_Y), 5'd6, 32'hAC50);
    add_row(5, mov_instr(`PIO_SRC_Y, `PIO_MOVOP_NONE, `PIO_SRC_Y), 5'd7, 32'hAC50);
    add_row(5, mov_instr(`PIO_SRC_Y, `PIO_MOVOP_NONE, `PIO_SRC_Y), 5'd2, 32'hAC50);
    nx_empty = 1'b0;
    nx_din   = 32'h0000_001B;
    fifo_row(5, encode_instr(`PIO_OP_PUSHPULL, 3'b101, 5'd0), 5'd3, 1'b0, 1'b1,
             32'h0, 32'hAC50);
    nx_empty = 1'b1;
    add_row(5, encode_instr(`PIO_OP_OUT, `PIO_DST_PC, 5'd5), 5'd27, 32'hAC50);
    add_row(5, mov_instr(`PIO_DST_PC, `PIO_MOVOP_NONE, `PIO_SRC_Y), 5'd6, 32'hAC50);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
    errors++;
    test_errs[cur_test]++;
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the next one
  task automatic apply_row(input row_t r);
    en         = r.en;
    instr      = r.instr;
    din        = r.din;
    full       = r.full;
    empty      = r.empty;
    input_pins = r.input_pins;
    #89;
    if (push !== r.exp_push) report_mismatch("push", 32'(r.exp_push), 32'(push));
    if (pull !== r.exp_pull) report_mismatch("pull", 32'(r.exp_pull), 32'(pull));
    if (dout !== r.exp_dout) report_mismatch("dout", r.exp_dout, dout);
    @(posedge clk);
    #1;
    if (pc !== r.exp_pc) report_mismatch("pc", 32'(r.exp_pc), 32'(pc));
    if (output_pins !== r.exp_pins) report_mismatch("output_pins", r.exp_pins, output_pins);
    if (pin_directions !== r.exp_dirs) begin
      report_mismatch("pin_directions", r.exp_dirs, pin_directions);
    end
  endtask

  initial begin
    clk        = 1'b0;
    en         = 1'b0;
    instr      = '0;
    din        = '0;
    full       = 1'b0;
    empty      = 1'b1;
    input_pins = '0;
    errors     = 0;
    tests_ok   = 0;
    tests_bad  = 0;
    cur_test   = 1;
    foreach (test_errs[i]) test_errs[i] = 0;
    build_table();
    cycles = 0;
    while (arst_n !== 1'b1 && cycles < RESET_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (arst_n !== 1'b1) begin
      $display("timeout: reset was not released within %0d cycles", RESET_LIMIT);
      tests_bad++;
      idx = rows.size();
    end else begin
      if (pc !== 5'd0) report_mismatch("pc", 32'h0, 32'(pc));
      if (push !== 1'b0) report_mismatch("push", 32'h0, 32'(push));
      if (pull !== 1'b0) report_mismatch("pull", 32'h0, 32'(pull));
      if (output_pins !== '0) report_mismatch("output_pins", 32'h0, output_pins);
      if (pin_directions !== '0) report_mismatch("pin_directions", 32'h0, pin_directions);
      @(posedge clk);
      #1;
      idx = 0;
    end
    while (idx < rows.size()) begin
      cur_test = rows[idx].test;
      steps    = 0;
      while (idx < rows.size() && rows[idx].test == cur_test && steps < STEP_LIMIT) begin
        apply_row(rows[idx]);
        idx++;
        steps++;
      end
      if (idx < rows.size() && rows[idx].test == cur_test) begin
        $display("timeout: test %0d ran past %0d steps", cur_test, STEP_LIMIT);
        errors++;
        test_errs[cur_test]++;
        while (idx < rows.size() && rows[idx].test == cur_test) begin
          idx++;
        end
      end
      if (test_errs[cur_test] == 0) begin
        $display("test %0d: %0d steps, ok", cur_test, steps);
        tests_ok++;
      end else begin
        $display("test %0d: %0d steps, %0d errors", cur_test, steps, test_errs[cur_test]);
        tests_bad++;
      end
    end
    $display("%0d tests ok, %0d tests failed, %0d errors", tests_ok, tests_bad, errors);
    if (tests_bad == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* pio_sm.f */
+incdir+design
design/pio_isa_pkg.sv
design/pio_wr_if.sv
design/pio_exec.sv
design/pio_pc.sv
design/pio_scratch.sv
design/pio_isr.sv
design/pio_osr.sv
design/pio_pins.sv
design/pio_sm.sv
verif/pio_sm_tb.sv

/* Makefile */
# Verilator simulation of the PIO state machine testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= pio_sm_tb
FILELIST  ?= pio_sm.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

# Fails unless the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
